// File: common/board_pkg.sv
`default_nettype none

package board_pkg;

  // playfield size, row 0 at the top
  localparam int PLAY_ROWS = 14;
  localparam int PLAY_COLS = 10;

  // left column of the piece box on spawn
  localparam int SPAWN_COL = 3;

  // row index of the piece box
  typedef logic [4:0] row_t;

  // column index of the piece box
  // signed, a rotated box may start left of column 0
  typedef logic signed [4:0] col_t;

  // settled blocks of one row, bit c is column c
  typedef logic [PLAY_COLS-1:0] row_bits_t;

  // whole playfield, row r in bits 10r +: 10
  typedef logic [PLAY_ROWS*PLAY_COLS-1:0] board_t;

endpackage

`default_nettype wire

// File: common/piece_pkg.sv
`default_nettype none

package piece_pkg;

  // 4x4 piece box, bit i is box row i/4, box column i%4
  typedef logic [15:0] shape_t;

  // piece kind, steps through the table in order
  typedef logic [2:0] kind_t;

  // cleared rows, wraps at 256
  typedef logic [7:0] score_t;

  function automatic shape_t shape_of(input kind_t kind);
    shape_t s;
    case (kind)
      3'd0:    s = 16'h0720;
      3'd1:    s = 16'h0660;
      3'd2:    s = 16'h00F0;
      3'd3:    s = 16'h0360;
      3'd4:    s = 16'h0630;
      3'd5:    s = 16'h0740;
      3'd6:    s = 16'h0E20;
      default: s = 16'h0660;
    endcase
    return s;
  endfunction

  // quarter turn clockwise inside the box
  // new (r, c) takes old (3-c, r)
  function automatic shape_t rotate_cw(input shape_t s);
    shape_t t;
    for (int r = 0; r < 4; r++)
    begin
      for (int c = 0; c < 4; c++)
      begin
        t[r*4 + c] = s[(3 - c)*4 + r];
      end
    end
    return t;
  endfunction

endpackage

`default_nettype wire

// File: piece/collision_check.sv
`default_nettype none

module collision_check (
  input  wire piece_pkg::shape_t shape,
  input  wire board_pkg::row_t   row,
  input  wire board_pkg::col_t   col,
  input  wire board_pkg::board_t board,
  output logic                   hit
);

  import board_pkg::*;

  // everything outside the playfield counts as occupied
  always_comb
  begin
    int r;
    int c;
    hit = 1'b0;
    for (int i = 0; i < 16; i++)
    begin
      r = int'(row) + i / 4;
      c = int'(col) + i % 4;
      if (shape[i])
      begin
        if (r >= PLAY_ROWS || c < 0 || c >= PLAY_COLS)
          hit = 1'b1;
        else if (board[r*PLAY_COLS + c])
          hit = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: piece/piece_control.sv
`default_nettype none

module piece_control #(
  parameter int FALL_TICKS = 25_000_000
) (
  input  wire                clk,
  input  wire                rst_n,
  input  wire                move_right,
  input  wire                move_left,
  input  wire                rotate_r,
  input  wire                ingame_sig,
  input  wire board_pkg::board_t board,
  output board_pkg::row_t    piece_row,
  output board_pkg::col_t    piece_col,
  output piece_pkg::shape_t  piece_shape,
  output board_pkg::board_t  stamp,
  output logic               lock_piece,
  output logic               game_over
);

  import board_pkg::*;
  import piece_pkg::*;

  localparam int TICK_W = $clog2(FALL_TICKS);

  logic [TICK_W-1:0] tick_cnt;
  logic              fall_tick;
  kind_t             next_kind;
  shape_t            rot_shape;
  row_t              row_down;
  col_t              col_right;
  col_t              col_left;
  logic              hit_down;
  logic              hit_right;
  logic              hit_left;
  logic              hit_rot;

  // fall timer, only runs in game
  assign fall_tick = ingame_sig && (tick_cnt == TICK_W'(FALL_TICKS - 1));

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      tick_cnt <= '0;
    else if (fall_tick)
      tick_cnt <= '0;
    else if (ingame_sig)
      tick_cnt <= tick_cnt + 1'b1;
  end

  // candidate positions and shape
  assign row_down  = piece_row + row_t'(1);
  assign col_right = piece_col + col_t'(1);
  assign col_left  = piece_col - col_t'(1);
  assign rot_shape = rotate_cw(piece_shape);

  collision_check u_hit_down (
    .shape (piece_shape),
    .row   (row_down),
    .col   (piece_col),
    .board (board),
    .hit   (hit_down)
  );

  collision_check u_hit_right (
    .shape (piece_shape),
    .row   (piece_row),
    .col   (col_right),
    .board (board),
    .hit   (hit_right)
  );

  collision_check u_hit_left (
    .shape (piece_shape),
    .row   (piece_row),
    .col   (col_left),
    .board (board),
    .hit   (hit_left)
  );

  collision_check u_hit_rot (
    .shape (rot_shape),
    .row   (piece_row),
    .col   (piece_col),
    .board (board),
    .hit   (hit_rot)
  );

  // blocked tick, settle on the following cycle
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      lock_piece <= 1'b0;
    else
      lock_piece <= fall_tick && hit_down;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      piece_row <= '0;
      piece_col <= col_t'(SPAWN_COL);
    end
    else if (lock_piece)
    begin
      piece_row <= '0;
      piece_col <= col_t'(SPAWN_COL);
    end
    else if (move_right && !hit_right)
      piece_col <= col_right;
    else if (move_left && !hit_left)
      piece_col <= col_left;
    else if (fall_tick && !hit_down)
      piece_row <= row_down;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      piece_shape <= shape_of(kind_t'(0));
      next_kind   <= kind_t'(1);
    end
    else if (lock_piece)
    begin
      piece_shape <= shape_of(next_kind);
      next_kind   <= next_kind + 1'b1;
    end
    else if (rotate_r && !hit_rot)
      piece_shape <= rot_shape;
  end

  // no room at the spawn point
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      game_over <= 1'b0;
    else if (piece_row == '0 && piece_col == col_t'(SPAWN_COL) && hit_down)
      game_over <= 1'b1;
  end

  // piece cells projected onto the playfield
  always_comb
  begin
    int r;
    int c;
    stamp = '0;
    for (int i = 0; i < 16; i++)
    begin
      r = int'(piece_row) + i / 4;
      c = int'(piece_col) + i % 4;
      if (piece_shape[i] && r < PLAY_ROWS && c >= 0 && c < PLAY_COLS)
        stamp[r*PLAY_COLS + c] = 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: logic/board_row.sv
`default_nettype none

module board_row (
  input  wire                        clk,
  input  wire                        rst_n,
  input  wire                        lock_piece,
  input  wire                        shift,
  input  wire board_pkg::row_bits_t  above,
  input  wire board_pkg::row_bits_t  stamp_bits,
  output board_pkg::row_bits_t       bits,
  output logic                       full
);

  // a shift wins over a stamp in the same cycle
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      bits <= '0;
    else if (shift)
      bits <= above;
    else if (lock_piece)
      bits <= bits | stamp_bits;
  end

  assign full = &bits;

endmodule

`default_nettype wire

// File: logic/line_clear.sv
`default_nettype none

module line_clear (
  input  wire                               clk,
  input  wire                               rst_n,
  input  wire [board_pkg::PLAY_ROWS-1:0]    full_rows,
  output logic [board_pkg::PLAY_ROWS-1:0]   shift_rows,
  output piece_pkg::score_t                 score
);

  import board_pkg::*;

  logic any_full;

  assign any_full = |full_rows;

  // row r shifts when it or any row below it is full,
  // so everything above the bottom-most full row moves down
  always_comb
  begin
    logic below_full;
    below_full = 1'b0;
    for (int r = PLAY_ROWS - 1; r >= 0; r--)
    begin
      below_full    = below_full | full_rows[r];
      shift_rows[r] = below_full;
    end
  end

  // one cleared row per cycle
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      score <= '0;
    else if (any_full)
      score <= score + 1'b1;
  end

endmodule

`default_nettype wire

// File: logic/tetris_top.sv
`default_nettype none

module tetris_top #(
  parameter int FALL_TICKS = 25_000_000
) (
  input  wire                    clk,
  input  wire                    rst_n,
  input  wire                    move_right,
  input  wire                    move_left,
  input  wire                    rotate_r,
  input  wire                    ingame_sig,
  output board_pkg::row_t        piece_row,
  output board_pkg::col_t        piece_col,
  output piece_pkg::shape_t      piece_shape,
  output wire board_pkg::board_t board,
  output piece_pkg::score_t      score,
  output logic                   game_over
);

  import board_pkg::*;

  board_t               stamp;
  board_t               above_bus;
  logic                 lock_piece;
  wire [PLAY_ROWS-1:0]  full_rows;
  logic [PLAY_ROWS-1:0] shift_rows;

  // row r sees row r-1, row 0 sees an empty row
  assign above_bus = {board[PLAY_ROWS*PLAY_COLS-PLAY_COLS-1:0], {PLAY_COLS{1'b0}}};

  piece_control #(
    .FALL_TICKS (FALL_TICKS)
  ) u_piece (
    .clk         (clk),
    .rst_n       (rst_n),
    .move_right  (move_right),
    .move_left   (move_left),
    .rotate_r    (rotate_r),
    .ingame_sig  (ingame_sig),
    .board       (board),
    .piece_row   (piece_row),
    .piece_col   (piece_col),
    .piece_shape (piece_shape),
    .stamp       (stamp),
    .lock_piece  (lock_piece),
    .game_over   (game_over)
  );

  for (genvar r = 0; r < PLAY_ROWS; r++)
  begin : g_row
    board_row u_row (
      .clk        (clk),
      .rst_n      (rst_n),
      .lock_piece (lock_piece),
      .shift      (shift_rows[r]),
      .above      (above_bus[r*PLAY_COLS +: PLAY_COLS]),
      .stamp_bits (stamp[r*PLAY_COLS +: PLAY_COLS]),
      .bits       (board[r*PLAY_COLS +: PLAY_COLS]),
      .full       (full_rows[r])
    );
  end

  line_clear u_clear (
    .clk        (clk),
    .rst_n      (rst_n),
    .full_rows  (full_rows),
    .shift_rows (shift_rows),
    .score      (score)
  );

endmodule

`default_nettype wire

// File: dv/tetris_tb.sv
`default_nettype none

module tetris_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import board_pkg::*;
  import piece_pkg::*;

  localparam int FALL_TICKS = 16;

  logic      clk;
  logic      rst_n;
  logic      move_right;
  logic      move_left;
  logic      rotate_r;
  logic      ingame_sig;
  row_t      piece_row;
  col_t      piece_col;
  shape_t    piece_shape;
  board_t    board;
  score_t    score;
  logic      game_over;

  // reference model state
  board_t    m_board;
  shape_t    m_shape;
  kind_t     m_next;
  score_t    m_score;
  int        seed = 32'hf54e;
  int        errors = 0;
  int        checks = 0;

  tetris_top #(
    .FALL_TICKS (FALL_TICKS)
  ) uut (
    .clk         (clk),
    .rst_n       (rst_n),
    .move_right  (move_right),
    .move_left   (move_left),
    .rotate_r    (rotate_r),
    .ingame_sig  (ingame_sig),
    .piece_row   (piece_row),
    .piece_col   (piece_col),
    .piece_shape (piece_shape),
    .board       (board),
    .score       (score),
    .game_over   (game_over)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic compare(input logic [139:0] got, input logic [139:0] exp, input string what);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("mismatch at time %0t: %s got %0h expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic abort_on_timeout(input string what);
    $display("timeout while waiting for %s", what);
    $display("FAIL: see errors above");
    $finish;
  endtask

  function automatic logic collides(input shape_t s, input int row, input int col,
                                    input board_t b);
    int r;
    int c;
    for (int i = 0; i < 16; i++)
    begin
      r = row + i / 4;
      c = col + i % 4;
      if (s[i] && (r >= PLAY_ROWS || c < 0 || c >= PLAY_COLS))
        return 1'b1;
      if (s[i] && b[r*PLAY_COLS + c])
        return 1'b1;
    end
    return 1'b0;
  endfunction

  function automatic board_t project(input shape_t s, input int row, input int col);
    board_t b;
    b = '0;
    for (int i = 0; i < 16; i++)
    begin
      if (s[i])
        b[(row + i / 4)*PLAY_COLS + col + i % 4] = 1'b1;
    end
    return b;
  endfunction

  function automatic logic has_full_row(input board_t b);
    for (int r = 0; r < PLAY_ROWS; r++)
    begin
      if (&b[r*PLAY_COLS +: PLAY_COLS])
        return 1'b1;
    end
    return 1'b0;
  endfunction

  // bottom-most full row goes first
  // rows above it drop by one
  task automatic clear_model_rows();
    int p;
    p = PLAY_ROWS - 1;
    while (p >= 0)
    begin
      if (&m_board[p*PLAY_COLS +: PLAY_COLS])
      begin
        for (int r = p; r > 0; r--)
          m_board[r*PLAY_COLS +: PLAY_COLS] = m_board[(r-1)*PLAY_COLS +: PLAY_COLS];
        m_board[PLAY_COLS-1:0] = '0;
        m_score++;
      end
      else
        p--;
    end
  endtask

  // one column step with the move held for one cycle
  task automatic step_move(input logic right);
    @(posedge clk);
    move_right <= right;
    move_left  <= !right;
    @(posedge clk);
    move_right <= 1'b0;
    move_left  <= 1'b0;
    @(negedge clk);
  endtask

  task automatic wait_lock_pulse();
    int n;
    n = 0;
    @(negedge clk);
    while (!uut.lock_piece)
    begin
      n++;
      if (n > FALL_TICKS * 20)
        abort_on_timeout("lock pulse");
      @(negedge clk);
    end
  endtask

  task automatic drop_at(input int target);
    int n;
    int land;
    n = 0;
    while (int'(piece_col) != target)
    begin
      n++;
      if (n > 20)
        abort_on_timeout("piece to reach target column");
      step_move(int'(piece_col) < target);
    end
    land = 0;
    while (!collides(m_shape, land + 1, target, m_board))
      land++;
    m_board = m_board | project(m_shape, land, target);
    clear_model_rows();
    m_shape = shape_of(m_next);
    m_next  = m_next + 1'b1;
    @(posedge clk);
    ingame_sig <= 1'b1;
    wait_lock_pulse();
    @(posedge clk);
    ingame_sig <= 1'b0;
    n = 0;
    @(negedge clk);
    while (has_full_row(board))
    begin
      n++;
      if (n > 10)
        abort_on_timeout("full rows to clear");
      @(negedge clk);
    end
    compare(board, m_board, "board after drop");
    compare(score, m_score, "score");
    compare(piece_shape, m_shape, "spawned shape");
    compare(piece_row, 0, "spawn row");
    compare(piece_col, SPAWN_COL, "spawn column");
  endtask

  task automatic reset_state_test();
    compare(piece_shape, 16'h0720, "reset shape");
    compare(piece_row, 0, "reset row");
    compare(piece_col, 3, "reset column");
    compare(board, '0, "reset board");
    compare(score, 0, "reset score");
    compare(game_over, 0, "reset game_over");
    $display("test reset_state done, errors %0d", errors);
  endtask

  task automatic moves_and_walls_test();
    @(posedge clk);
    move_right <= 1'b1;
    for (int k = 1; k <= 6; k++)
    begin
      @(posedge clk);
      @(negedge clk);
      compare(piece_col, (3 + k > 7) ? 7 : 3 + k, "column while moving right");
    end
    @(posedge clk);
    move_right <= 1'b0;
    move_left  <= 1'b1;
    for (int k = 1; k <= 9; k++)
    begin
      @(posedge clk);
      @(negedge clk);
      compare(piece_col, (7 - k < 0) ? 0 : 7 - k, "column while moving left");
    end
    @(posedge clk);
    move_left <= 1'b0;
    for (int k = 0; k < 3; k++)
      step_move(1'b1);
    compare(piece_col, 3, "column back at spawn");
    $display("test moves_and_walls done, errors %0d", errors);
  endtask

  task automatic rotation_test();
    shape_t prev;
    prev = piece_shape;
    for (int k = 0; k < 4; k++)
    begin
      @(posedge clk);
      rotate_r <= 1'b1;
      @(posedge clk);
      rotate_r <= 1'b0;
      @(negedge clk);
      compare(piece_shape, rotate_cw(prev), "rotated shape");
      prev = rotate_cw(prev);
    end
    compare(piece_shape, 16'h0720, "shape after four turns");
    $display("test rotation done, errors %0d", errors);
  endtask

  task automatic fall_and_lock_test();
    int land;
    int n;
    int since;
    int last_row;
    logic stepped;
    land = 0;
    while (!collides(m_shape, land + 1, 3, m_board))
      land++;
    n = 0;
    since = 0;
    stepped = 1'b0;
    last_row = int'(piece_row);
    @(posedge clk);
    ingame_sig <= 1'b1;
    @(negedge clk);
    while (!uut.lock_piece)
    begin
      n++;
      since++;
      if (n > FALL_TICKS * 20)
        abort_on_timeout("piece to land");
      if (int'(piece_row) != last_row)
      begin
        compare(piece_row, last_row + 1, "row after fall tick");
        if (stepped)
          compare(since, FALL_TICKS, "cycles between fall steps");
        stepped = 1'b1;
        since = 0;
        last_row = int'(piece_row);
      end
      @(negedge clk);
    end
    compare(piece_row, land, "landing row");
    m_board = m_board | project(m_shape, land, 3);
    m_shape = shape_of(m_next);
    m_next  = m_next + 1'b1;
    @(posedge clk);
    ingame_sig <= 1'b0;
    @(negedge clk);
    compare(board, m_board, "board after lock");
    compare(piece_shape, shape_of(kind_t'(1)), "next shape");
    compare(piece_row, 0, "row after respawn");
    compare(piece_col, 3, "column after respawn");
    $display("test fall_and_lock done, errors %0d", errors);
  endtask

  task automatic line_clear_test();
    int lo;
    int hi;
    int target;
    for (int k = 0; k < 10; k++)
    begin
      lo = 3;
      hi = 3;
      while (!collides(m_shape, 0, lo - 1, m_board))
        lo--;
      while (!collides(m_shape, 0, hi + 1, m_board))
        hi++;
      target = lo + ($unsigned($random(seed)) % (hi - lo + 1));
      drop_at(target);
    end
    $display("test line_clear done, errors %0d", errors);
  endtask

  task automatic game_over_test();
    int n;
    n = 0;
    while (!collides(m_shape, 1, 3, m_board))
    begin
      n++;
      if (n > 20)
        abort_on_timeout("a blocked spawn");
      compare(game_over, 1'b0, "game_over while the spawn is free");
      drop_at(3);
    end
    n = 0;
    @(negedge clk);
    while (!game_over)
    begin
      n++;
      if (n > 10)
        abort_on_timeout("game_over to rise");
      @(negedge clk);
    end
    for (int k = 0; k < 20; k++)
    begin
      @(negedge clk);
      compare(game_over, 1'b1, "sticky game_over");
    end
    $display("test game_over done, errors %0d", errors);
  endtask

  initial
  begin
    rst_n      = 1'b0;
    move_right = 1'b0;
    move_left  = 1'b0;
    rotate_r   = 1'b0;
    ingame_sig = 1'b0;
    m_board    = '0;
    m_shape    = shape_of(kind_t'(0));
    m_next     = kind_t'(1);
    m_score    = '0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    reset_state_test();
    moves_and_walls_test();
    rotation_test();
    fall_and_lock_test();
    line_clear_test();
    game_over_test();
    $display("done: %0d checks, %0d errors", checks, errors);
    if (errors == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

endmodule

`default_nettype wire

// File: files.f
common/board_pkg.sv
common/piece_pkg.sv
piece/collision_check.sv
piece/piece_control.sv
logic/board_row.sv
logic/line_clear.sv
logic/tetris_top.sv
dv/tetris_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator, pass only if the pass line shows up
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f files.f --top-module tetris_tb -o tetris_sim \
  || { echo "build failed"; exit 1; }

./obj_dir/tetris_sim | tee /dev/stderr | grep -q "^PASS: all tests$" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
